// ==== spw_tx.f ====
+incdir+design
design/spw_char_pkg.sv
design/spw_tx_ctrl_pkg.sv
design/spw_tx_flow_ctrl.sv
design/spw_tx_sequencer.sv
design/spw_tx_serializer.sv
design/spw_tx.sv
tests/spw_tx_tb.sv

// ==== Bender.yml ====
package:
  name: spw_tx

sources:
  - include_dirs:
      - design
    files:
      - design/spw_char_pkg.sv
      - design/spw_tx_ctrl_pkg.sv
      - design/spw_tx_flow_ctrl.sv
      - design/spw_tx_sequencer.sv
      - design/spw_tx_serializer.sv
      - design/spw_tx.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/spw_tx_tb.sv

// ==== tests/spw_tx_tb.sv ====
`timescale 1ns/10ps

module spw_tx_tb;

	localparam int KIND_NULL = 0;
	localparam int KIND_FCT = 1;
	localparam int KIND_DATA = 2;
	localparam int KIND_EOP = 3;
	localparam int KIND_EEP = 4;
	localparam int WAIT_LIMIT = 3000;

	logic pclk_tx;
	logic enable_tx;
	logic send_null_tx;
	logic send_fct_tx;
	logic [8:0] data_tx_i;
	logic txwrite_tx;
	logic gotfct_tx;
	logic send_fct_now;
	logic tx_dout_e;
	logic tx_sout_e;
	logic ready_tx_data;

	integer seed;
	int seen [5];
	logic [8:0] words_q [$];
	logic [8:0] exp_q [$];
	int dec_kind_q [$];
	logic [7:0] dec_pay_q [$];
	logic [9:0] dec_bits_q [$];

	// Line decoder state
	logic started;
	logic cur;
	logic prev_d;
	logic prev_s;
	logic ready_due;
	logic [9:0] bits;
	int nbits;

	spw_tx spw_tx_inst (
		.pclk_tx(pclk_tx), .enable_tx(enable_tx),
		.send_null_tx(send_null_tx), .send_fct_tx(send_fct_tx),
		.data_tx_i(data_tx_i), .txwrite_tx(txwrite_tx),
		.gotfct_tx(gotfct_tx), .send_fct_now(send_fct_now),
		.tx_dout_e(tx_dout_e), .tx_sout_e(tx_sout_e), .ready_tx_data(ready_tx_data)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever
			#20 pclk_tx = ~pclk_tx;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout: %s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	// --------------------------------------------------
	// Reference model of one character on the line
	// --------------------------------------------------
	function automatic logic [9:0] expected_bits(input int kind, input logic [7:0] pay,
		input logic prev_par);
		logic [9:0] b;
		logic flag;
		int i;
		b = '0;
		flag = (kind != KIND_DATA);
		b[0] = ~(prev_par ^ flag);
		b[1] = flag;
		case (kind)
			KIND_DATA:
			begin
				for (i = 0; i < 8; i++)
					b[2 + i] = pay[i];
			end
			KIND_EOP:
				b[3] = 1'b1;
			KIND_EEP:
				b[2] = 1'b1;
			KIND_NULL:
			begin
				// ESC code 11, then an FCT whose parity follows ESC
				b[2] = 1'b1;
				b[3] = 1'b1;
				b[4] = ~(1'b1 ^ 1'b1 ^ 1'b1);
				b[5] = 1'b1;
			end
			default:
				b[3:2] = 2'b00;
		endcase
		return b;
	endfunction

	function automatic logic payload_parity(input int kind, input logic [7:0] pay);
		if (kind == KIND_DATA)
			return ^pay;
		if (kind == KIND_EOP || kind == KIND_EEP)
			return 1'b1;
		return 1'b0;
	endfunction

	function automatic int word_kind(input logic [8:0] word);
		if (!word[8])
			return KIND_DATA;
		if (word[1:0] == 2'b01)
			return KIND_EEP;
		return KIND_EOP;
	endfunction

	// --------------------------------------------------
	// Line decoder, also feeds the word queue
	// --------------------------------------------------
	task automatic advance();
		logic d;
		logic s;
		@(negedge pclk_tx);
		d = tx_dout_e;
		s = tx_sout_e;
		check_value("ds_one_change", 1, (d ^ prev_d) ^ (s ^ prev_s));
		check_value("ready_tx_data", ready_due, ready_tx_data);
		ready_due = 1'b0;
		if (!txwrite_tx && words_q.size() > 0)
		begin
			data_tx_i = words_q.pop_front();
			txwrite_tx = 1'b1;
		end
		prev_d = d;
		prev_s = s;
		cur = d;
	endtask

	task automatic take_bit();
		if (nbits != 0)
			advance();
		bits[nbits] = cur;
		nbits++;
	endtask

	initial
	begin : line_decoder
		int wait_cnt;
		int kind;
		logic [7:0] pay;
		wait_cnt = 0;
		started = 1'b0;
		ready_due = 1'b0;
		while (!started)
		begin
			@(negedge pclk_tx);
			if (enable_tx && (tx_dout_e || tx_sout_e))
				started = 1'b1;
			else
			begin
				wait_cnt++;
				if (wait_cnt > WAIT_LIMIT)
					timeout_fail("no activity on the data/strobe pair");
			end
		end
		prev_d = tx_dout_e;
		prev_s = tx_sout_e;
		cur = tx_dout_e;
		forever
		begin
			bits = '0;
			nbits = 0;
			pay = '0;
			take_bit();
			take_bit();
			if (!bits[1])
			begin
				repeat (8)
					take_bit();
				kind = KIND_DATA;
				pay = bits[9:2];
			end
			else
			begin
				take_bit();
				take_bit();
				case (bits[3:2])
					2'b11:
					begin
						repeat (4)
							take_bit();
						kind = KIND_NULL;
					end
					2'b10: kind = KIND_EOP;
					2'b01: kind = KIND_EEP;
					default: kind = KIND_FCT;
				endcase
			end
			// N-char done, next word goes up before the next load
			if (kind == KIND_DATA || kind == KIND_EOP || kind == KIND_EEP)
			begin
				ready_due = 1'b1;
				if (words_q.size() > 0)
					data_tx_i = words_q.pop_front();
				else
					txwrite_tx = 1'b0;
			end
			seen[kind]++;
			dec_kind_q.push_back(kind);
			dec_pay_q.push_back(pay);
			dec_bits_q.push_back(bits);
			advance();
		end
	end

	// --------------------------------------------------
	// Compare decoded characters with the reference
	// --------------------------------------------------
	initial
	begin : compare
		int kind;
		logic [7:0] pay;
		logic [9:0] got;
		logic [8:0] word;
		logic prev_par;
		prev_par = 1'b0;
		forever
		begin
			@(posedge pclk_tx);
			while (dec_kind_q.size() > 0)
			begin
				kind = dec_kind_q.pop_front();
				pay = dec_pay_q.pop_front();
				got = dec_bits_q.pop_front();
				if (kind == KIND_DATA || kind == KIND_EOP || kind == KIND_EEP)
				begin
					if (exp_q.size() == 0)
					begin
						$display("An N-char went out with no word written");
						$display("Verification failed");
						$fatal(1);
					end
					word = exp_q.pop_front();
					check_value("nchar_kind", word_kind(word), kind);
					if (kind == KIND_DATA)
						check_value("data_byte", word[7:0], pay);
				end
				check_value("char_bits", expected_bits(kind, pay, prev_par), got);
				prev_par = payload_parity(kind, pay);
			end
		end
	end

	task automatic wait_seen(input int kind, input int target, input string what);
		int n;
		n = 0;
		while (seen[kind] < target)
		begin
			@(posedge pclk_tx);
			n++;
			if (n > WAIT_LIMIT)
				timeout_fail(what);
		end
	endtask

	task automatic push_word(input logic [8:0] word);
		words_q.push_back(word);
		exp_q.push_back(word);
	endtask

	task automatic push_random(input int count);
		repeat (count)
			push_word({1'b0, 8'($random(seed))});
	endtask

	task automatic pulse_gotfct();
		@(negedge pclk_tx);
		gotfct_tx = 1'b1;
		@(negedge pclk_tx);
		gotfct_tx = 1'b0;
		@(posedge pclk_tx);
	endtask

	initial
	begin
		int fct_base;
		int n;
		seed = 80;
		enable_tx = 1'b0;
		send_null_tx = 1'b0;
		send_fct_tx = 1'b0;
		data_tx_i = '0;
		txwrite_tx = 1'b0;
		gotfct_tx = 1'b0;
		send_fct_now = 1'b0;
		seen = '{default: 0};

		// Quiet line through reset and after it
		repeat (10)
		begin
			@(negedge pclk_tx);
			check_value("reset_quiet", 3'b000, {tx_dout_e, tx_sout_e, ready_tx_data});
		end
		enable_tx = 1'b1;
		repeat (5)
		begin
			@(negedge pclk_tx);
			check_value("idle_quiet", 3'b000, {tx_dout_e, tx_sout_e, ready_tx_data});
		end

		// NULLs only
		send_null_tx = 1'b1;
		wait_seen(KIND_NULL, 5, "NULLs after send_null_tx");
		check_value("null_only_fct", 0, seen[KIND_FCT]);

		// Seven FCTs, then NULLs with zero credit
		@(posedge pclk_tx);
		push_random(8);
		push_word(9'h100);
		push_word(9'h101);
		@(negedge pclk_tx);
		send_fct_tx = 1'b1;
		wait_seen(KIND_FCT, 7, "initial FCTs");
		wait_seen(KIND_NULL, seen[KIND_NULL] + 3, "NULLs after FCTs");
		check_value("initial_fct_count", 7, seen[KIND_FCT]);
		check_value("no_credit_data", 0, seen[KIND_DATA]);

		// One credit step, eight data characters
		pulse_gotfct();
		wait_seen(KIND_DATA, 8, "eight data characters");
		wait_seen(KIND_NULL, seen[KIND_NULL] + 3, "NULLs after credit ran out");
		check_value("credit_data_count", 8, seen[KIND_DATA]);
		check_value("eop_held", 0, seen[KIND_EOP]);

		// EOP and EEP, then the six credits left
		pulse_gotfct();
		wait_seen(KIND_EEP, 1, "EEP character");
		check_value("eop_count", 1, seen[KIND_EOP]);
		@(posedge pclk_tx);
		push_random(7);
		wait_seen(KIND_DATA, 14, "data after EOP and EEP");
		wait_seen(KIND_NULL, seen[KIND_NULL] + 3, "NULLs after second credit");
		check_value("second_data_count", 14, seen[KIND_DATA]);

		// Held request gives one FCT
		fct_base = seen[KIND_FCT];
		@(negedge pclk_tx);
		send_fct_now = 1'b1;
		repeat (5)
			@(negedge pclk_tx);
		send_fct_now = 1'b0;
		wait_seen(KIND_FCT, fct_base + 1, "requested FCT");
		wait_seen(KIND_NULL, seen[KIND_NULL] + 3, "NULLs after requested FCT");
		check_value("requested_fct_count", fct_base + 1, seen[KIND_FCT]);
		check_value("data_before_credit", 14, seen[KIND_DATA]);
		pulse_gotfct();
		wait_seen(KIND_DATA, 15, "last data character");
		check_value("fct_before_data", fct_base + 1, seen[KIND_FCT]);
		wait_seen(KIND_NULL, seen[KIND_NULL] + 2, "final NULLs");

		n = 0;
		while (dec_kind_q.size() > 0 || exp_q.size() > 0)
		begin
			@(posedge pclk_tx);
			n++;
			if (n > WAIT_LIMIT)
				timeout_fail("characters left unchecked");
		end
		@(posedge pclk_tx);

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== design/spw_tx.sv ====
`timescale 1ns/10ps

`include "spw_tx_macros.svh"

module spw_tx (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic send_null_tx,
	input  logic send_fct_tx,
	input  logic [`SPW_WORD_W-1:0] data_tx_i,
	input  logic txwrite_tx,
	input  logic gotfct_tx,
	input  logic send_fct_now,
	output logic tx_dout_e,
	output logic tx_sout_e,
	output logic ready_tx_data
);

	logic credit_avail;
	logic fct_pending;
	logic fct_sent;
	logic nchar_sent;
	logic char_load;
	logic char_busy;
	logic char_last;
	spw_char_pkg::char_kind_e char_kind;
	spw_char_pkg::tx_word_u char_word;

	spw_tx_flow_ctrl flow_ctrl_inst (
		.pclk_tx(pclk_tx), .enable_tx(enable_tx),
		.gotfct_tx(gotfct_tx), .send_fct_now(send_fct_now),
		.fct_sent(fct_sent), .nchar_sent(nchar_sent),
		.credit_avail(credit_avail), .fct_pending(fct_pending)
	);

	spw_tx_sequencer sequencer_inst (
		.pclk_tx(pclk_tx), .enable_tx(enable_tx),
		.send_null_tx(send_null_tx), .send_fct_tx(send_fct_tx),
		.txwrite_tx(txwrite_tx), .data_tx_i(data_tx_i),
		.credit_avail(credit_avail), .fct_pending(fct_pending),
		.char_busy(char_busy), .char_last(char_last),
		.char_load(char_load), .char_kind(char_kind), .char_word(char_word),
		.fct_sent(fct_sent), .nchar_sent(nchar_sent), .ready_tx_data(ready_tx_data)
	);

	spw_tx_serializer serializer_inst (
		.pclk_tx(pclk_tx), .enable_tx(enable_tx),
		.char_load(char_load), .char_kind(char_kind), .char_word(char_word),
		.char_busy(char_busy), .char_last(char_last),
		.tx_dout_e(tx_dout_e), .tx_sout_e(tx_sout_e)
	);

endmodule

// ==== design/spw_tx_serializer.sv ====
`timescale 1ns/10ps

`include "spw_tx_macros.svh"

module spw_tx_serializer (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic char_load,
	input  spw_char_pkg::char_kind_e char_kind,
	input  spw_char_pkg::tx_word_u char_word,
	output logic char_busy,
	output logic char_last,
	output logic tx_dout_e,
	output logic tx_sout_e
);

	localparam logic [`SPW_BITCNT_W-1:0] LEN_NULL = `SPW_NULL_LEN;
	localparam logic [`SPW_BITCNT_W-1:0] LEN_FCT = `SPW_FCT_LEN;
	localparam logic [`SPW_BITCNT_W-1:0] LEN_DATA = `SPW_DATA_LEN;
	localparam logic [`SPW_BITCNT_W-1:0] LEN_EOP = `SPW_EOP_LEN;

	spw_char_pkg::char_kind_e ld_kind;
	spw_char_pkg::tx_word_u ld_word;
	logic [`SPW_BITCNT_W-1:0] bit_idx;
	logic [`SPW_BITCNT_W-1:0] last_idx;
	logic prev_par;
	logic next_bit;
	logic next_sout;

	function automatic logic [`SPW_BITCNT_W-1:0] char_len(input spw_char_pkg::char_kind_e kind);
		case (kind)
			spw_char_pkg::NULL: return LEN_NULL;
			spw_char_pkg::FCT: return LEN_FCT;
			spw_char_pkg::DATA: return LEN_DATA;
			default: return LEN_EOP;
		endcase
	endfunction

	// XOR of the payload bits, used by the next parity bit
	function automatic logic payload_par(input spw_char_pkg::char_kind_e kind,
		input spw_char_pkg::tx_word_u word);
		case (kind)
			spw_char_pkg::DATA: return ^word.d.data;
			spw_char_pkg::EOP, spw_char_pkg::EEP: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// --------------------------------------------------
	// Line bit by kind and position
	// --------------------------------------------------
	function automatic logic char_bit(input spw_char_pkg::char_kind_e kind,
		input spw_char_pkg::tx_word_u word, input logic [`SPW_BITCNT_W-1:0] idx,
		input logic par_in);
		logic flag;
		logic [`SPW_BITCNT_W-1:0] pos;
		flag = (kind != spw_char_pkg::DATA);
		pos = idx - `SPW_BITCNT_W'd2;
		if (idx == '0)
			return ~(par_in ^ flag);
		if (idx == `SPW_BITCNT_W'd1)
			return flag;
		case (kind)
			spw_char_pkg::DATA: return word.d.data[pos[2:0]];
			spw_char_pkg::EOP: return (idx == `SPW_BITCNT_W'd3);
			spw_char_pkg::EEP: return (idx == `SPW_BITCNT_W'd2);
			// ESC 11, then FCT with parity 0 after even ESC payload
			spw_char_pkg::NULL: return (pos == 'd0 || pos == 'd1 || pos == 'd3);
			default: return 1'b0;
		endcase
	endfunction

	assign last_idx = char_len(ld_kind) - 1'b1;
	assign char_last = char_busy && (bit_idx == last_idx);

	always_comb
	begin
		if (char_load)
			next_bit = char_bit(char_kind, char_word, '0, prev_par);
		else
			next_bit = char_bit(ld_kind, ld_word, bit_idx + 1'b1, prev_par);
		// Strobe flips only when data repeats
		next_sout = (next_bit == tx_dout_e) ? ~tx_sout_e : tx_sout_e;
	end

	always_ff @(posedge pclk_tx)
	begin
		if (char_load)
			ld_word <= char_word;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			ld_kind <= spw_char_pkg::NULL;
			bit_idx <= '0;
			char_busy <= 1'b0;
			prev_par <= 1'b0;
			tx_dout_e <= 1'b0;
			tx_sout_e <= 1'b0;
		end
		else if (char_load)
		begin
			ld_kind <= char_kind;
			bit_idx <= '0;
			char_busy <= 1'b1;
			prev_par <= payload_par(char_kind, char_word);
			tx_dout_e <= next_bit;
			tx_sout_e <= next_sout;
		end
		else if (char_busy)
		begin
			if (char_last)
				char_busy <= 1'b0;
			else
			begin
				bit_idx <= bit_idx + 1'b1;
				tx_dout_e <= next_bit;
				tx_sout_e <= next_sout;
			end
		end
	end

	a_ds_one_change: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!($changed(tx_dout_e) && $changed(tx_sout_e)));

endmodule

// ==== design/spw_tx_sequencer.sv ====
`timescale 1ns/10ps

`include "spw_tx_macros.svh"

module spw_tx_sequencer (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic send_null_tx,
	input  logic send_fct_tx,
	input  logic txwrite_tx,
	input  spw_char_pkg::tx_word_u data_tx_i,
	input  logic credit_avail,
	input  logic fct_pending,
	input  logic char_busy,
	input  logic char_last,
	output logic char_load,
	output spw_char_pkg::char_kind_e char_kind,
	output spw_char_pkg::tx_word_u char_word,
	output logic fct_sent,
	output logic nchar_sent,
	output logic ready_tx_data
);

	spw_tx_ctrl_pkg::link_state_e link_state;
	spw_tx_ctrl_pkg::link_state_e link_next;
	spw_char_pkg::char_kind_e nchar_kind;
	logic boundary;
	logic load_nchar;
	logic in_nchar;

	// Serializer idle or on the final bit of a character
	assign boundary = !char_busy || char_last;

	// --------------------------------------------------
	// Link state
	// --------------------------------------------------
	always_comb
	begin
		link_next = link_state;
		case (link_state)
			spw_tx_ctrl_pkg::IDLE:
			begin
				if (send_null_tx)
					link_next = spw_tx_ctrl_pkg::NULL_ONLY;
			end
			spw_tx_ctrl_pkg::NULL_ONLY:
			begin
				if (boundary && !send_null_tx)
					link_next = spw_tx_ctrl_pkg::IDLE;
				else if (send_fct_tx)
					link_next = spw_tx_ctrl_pkg::RUN;
			end
			spw_tx_ctrl_pkg::RUN:
			begin
				if (boundary && !send_null_tx)
					link_next = spw_tx_ctrl_pkg::IDLE;
			end
			default:
			begin
				link_next = spw_tx_ctrl_pkg::IDLE;
			end
		endcase
	end

	// --------------------------------------------------
	// Next character
	// --------------------------------------------------
	always_comb
	begin
		if (!data_tx_i.c.ctrl)
			nchar_kind = spw_char_pkg::DATA;
		else
		begin
			case (data_tx_i.c.code)
				`SPW_CODE_EOP: nchar_kind = spw_char_pkg::EOP;
				`SPW_CODE_EEP: nchar_kind = spw_char_pkg::EEP;
				default: nchar_kind = spw_char_pkg::EOP;
			endcase
		end
	end

	always_comb
	begin
		char_kind = spw_char_pkg::NULL;
		if (link_state == spw_tx_ctrl_pkg::RUN)
		begin
			if (fct_pending)
				char_kind = spw_char_pkg::FCT;
			else if (txwrite_tx && credit_avail)
				char_kind = nchar_kind;
		end
	end

	// A falling send_null_tx stops the line at the boundary
	assign char_load = boundary && send_null_tx && (link_state != spw_tx_ctrl_pkg::IDLE);

	// Word goes with the load, serializer keeps its own copy
	assign char_word = data_tx_i;

	assign load_nchar = char_load && (char_kind == spw_char_pkg::DATA
		|| char_kind == spw_char_pkg::EOP || char_kind == spw_char_pkg::EEP);
	assign fct_sent = char_load && (char_kind == spw_char_pkg::FCT);
	assign nchar_sent = load_nchar;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			link_state <= spw_tx_ctrl_pkg::IDLE;
			in_nchar <= 1'b0;
			ready_tx_data <= 1'b0;
		end
		else
		begin
			link_state <= link_next;
			if (char_load)
				in_nchar <= load_nchar;
			// One clock after the last N-char bit is on the line
			ready_tx_data <= char_last && in_nchar;
		end
	end

	a_load_at_boundary: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		char_load |-> (!char_busy || char_last));

endmodule

// ==== design/spw_tx_flow_ctrl.sv ====
`timescale 1ns/10ps

`include "spw_tx_macros.svh"

module spw_tx_flow_ctrl (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic gotfct_tx,
	input  logic send_fct_now,
	input  logic fct_sent,
	input  logic nchar_sent,
	output logic credit_avail,
	output logic fct_pending
);

	localparam logic [`SPW_CREDIT_W:0] CREDIT_STEP = `SPW_CREDIT_STEP;
	localparam logic [`SPW_CREDIT_W-1:0] CREDIT_MAX = `SPW_CREDIT_MAX;
	localparam logic [`SPW_FCT_PEND_W-1:0] PEND_INIT = `SPW_FCT_PEND_INIT;
	localparam logic [`SPW_FCT_PEND_W-1:0] PEND_MAX = '1;

	logic got_q;
	logic req_q;
	logic got_edge;
	logic req_edge;
	logic [`SPW_CREDIT_W-1:0] credit;
	logic [`SPW_CREDIT_W-1:0] credit_next;
	logic [`SPW_CREDIT_W:0] credit_sum;
	logic [`SPW_FCT_PEND_W-1:0] fct_pend;
	logic [`SPW_FCT_PEND_W-1:0] fct_pend_next;

	// Count each request once, however long it is held
	assign got_edge = gotfct_tx & ~got_q;
	assign req_edge = send_fct_now & ~req_q;

	// --------------------------------------------------
	// Receive credit
	// --------------------------------------------------
	always_comb
	begin
		credit_sum = {1'b0, credit} + (got_edge ? CREDIT_STEP : '0)
			- {{`SPW_CREDIT_W{1'b0}}, nchar_sent};
		if (credit_sum > {1'b0, CREDIT_MAX})
			credit_next = CREDIT_MAX;
		else
			credit_next = credit_sum[`SPW_CREDIT_W-1:0];
	end

	// --------------------------------------------------
	// Outgoing FCTs owed
	// --------------------------------------------------
	always_comb
	begin
		fct_pend_next = fct_pend;
		case ({req_edge, fct_sent})
			2'b10:
			begin
				if (fct_pend != PEND_MAX)
					fct_pend_next = fct_pend + 1'b1;
			end
			2'b01:
			begin
				fct_pend_next = fct_pend - 1'b1;
			end
			default:
			begin
				fct_pend_next = fct_pend;
			end
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			got_q <= 1'b0;
			req_q <= 1'b0;
			credit <= '0;
			fct_pend <= PEND_INIT;
		end
		else
		begin
			got_q <= gotfct_tx;
			req_q <= send_fct_now;
			credit <= credit_next;
			fct_pend <= fct_pend_next;
		end
	end

	assign credit_avail = (credit != '0);
	assign fct_pending = (fct_pend != '0);

	a_credit_limit: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		credit <= CREDIT_MAX);

	// Sequencer must hold off N-chars until credit arrives
	a_nchar_needs_credit: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		nchar_sent |-> (credit != '0));

endmodule

// ==== design/spw_tx_ctrl_pkg.sv ====
package spw_tx_ctrl_pkg;

	// IDLE        line quiet
	// NULL_ONLY   NULLs while the link starts up
	// RUN         FCT, N-chars and NULL fill
	typedef enum logic [1:0]
	{
		IDLE,
		NULL_ONLY,
		RUN
	} link_state_e;

endpackage

// ==== design/spw_char_pkg.sv ====
`include "spw_tx_macros.svh"

package spw_char_pkg;

	// Character kinds put on the line
	typedef enum logic [2:0]
	{
		NULL,
		FCT,
		DATA,
		EOP,
		EEP
	} char_kind_e;

	// Normal character view
	typedef struct packed
	{
		logic ctrl;
		logic [`SPW_WORD_W-2:0] data;
	} tx_data_view_t;

	// End of packet view, only the low two bits matter
	typedef struct packed
	{
		logic ctrl;
		logic [5:0] pad;
		logic [1:0] code;
	} tx_ctrl_view_t;

	typedef union packed
	{
		tx_data_view_t d;
		tx_ctrl_view_t c;
	} tx_word_u;

endpackage

// ==== design/spw_tx_macros.svh ====
`ifndef SPW_TX_MACROS_SVH
`define SPW_TX_MACROS_SVH

// Transmit word is a control flag on top of one byte
`define SPW_WORD_W 9

// Bit position inside the current character
`define SPW_BITCNT_W 4

// Line bits per character, parity bit included
`define SPW_NULL_LEN 8
`define SPW_FCT_LEN 4
`define SPW_DATA_LEN 10
`define SPW_EOP_LEN 4

// Receive credit, one step per received FCT
`define SPW_CREDIT_W 6
`define SPW_CREDIT_STEP 8
`define SPW_CREDIT_MAX 56

// Outgoing FCTs still owed to the far end
`define SPW_FCT_PEND_W 3
`define SPW_FCT_PEND_INIT 7

// End codes in the low bits of a control word
`define SPW_CODE_EOP 2'b00
`define SPW_CODE_EEP 2'b01

`endif
